/* dac_params.svh */
// dac bridge sizing: sample widths, pacing ratio, fifo depth and sync depths
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// one I or Q component from the baseband
`define IQ_WIDTH          16
// packed I/Q word, q in the low half
`define IQ_PAIR_WIDTH     32
// two antenna lanes side by side
`define DAC_PACK_WIDTH    64

// acc_clk cycles per baseband sample, 2x zero stuffing
`define CLK_PER_SAMPLE    2

// entries in the clock crossing fifo, power of two
`define FIFO_DEPTH        32

// flops on the gray pointer chains
`define SYNC_STAGES       2
// flops on the slow control bits into dac_clk
`define SYNC_STAGES_CTRL  4

`endif

/* iq_pkg.sv */
// sample and lane types shared along the tx baseband to dac path
`include "dac_params.svh"

package iq_pkg;

    // one complex baseband sample as it sits in the fifo
    typedef struct packed {
        logic signed [`IQ_WIDTH-1:0] i; // in-phase, upper half of the word
        logic signed [`IQ_WIDTH-1:0] q; // quadrature, lower half
    } iq_sample_t;

    // which half of the packed dac word gets the sample
    typedef enum logic {
        LANE_LOW  = 1'b0, // antenna 0, bits 31:0
        LANE_HIGH = 1'b1  // antenna 1, bits 63:32
    } dac_lane_e;

endpackage

/* regs_pkg.sv */
// axi4-lite register map, response codes and channel states of the dac bridge
package regs_pkg;

    localparam int REG_ADDR_W = 4;                     // byte offset bits decoded
    localparam logic [31:0] DAC_INTF_ID = 32'hdac0_0102; // read-only block id

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_CTRL   = 4'h0, // bit0 src_sel, bit1 ant_flag
        REG_STATUS = 4'h4, // bit0 sticky overflow, write 1 to clear
        REG_ID     = 4'h8  // constant id
    } reg_addr_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10 // unmapped offset
    } axi_resp_e;

    typedef enum logic {WR_IDLE, WR_RESP} axi_wr_state_e;

    typedef enum logic {RD_IDLE, RD_DATA} axi_rd_state_e;

endpackage

/* dac_ctrl_regs.sv */
// axi4-lite slave holding the source select, antenna lane and sticky overflow
`timescale 1ns/1ps

module dac_ctrl_regs
    import iq_pkg::*, regs_pkg::*;
(
    input  logic                  acc_clk,
    input  logic                  acc_rstn,
    input  logic [REG_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_resp_e             bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [REG_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output axi_resp_e             rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic                  wr_full_hit,
    output logic                  src_sel,
    output dac_lane_e             ant_flag
);

    axi_wr_state_e wr_state;
    axi_rd_state_e rd_state;
    reg_addr_e     wr_addr;
    reg_addr_e     rd_addr;
    logic          wr_hs;
    logic          rd_hs;
    logic          overflow;
    logic          ovf_clear;

    assign wr_addr   = reg_addr_e'(awaddr);
    assign rd_addr   = reg_addr_e'(araddr);
    assign wr_hs     = awvalid && wvalid && (wr_state == WR_IDLE); // aw and w taken together
    assign awready   = wr_hs;
    assign wready    = wr_hs;
    assign bvalid    = (wr_state == WR_RESP);
    assign ovf_clear = wr_hs && (wr_addr == REG_STATUS) && wstrb[0] && wdata[0];

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            wr_state <= WR_IDLE;
            bresp    <= OKAY;
            src_sel  <= 1'b0;     // dma path after reset
            ant_flag <= LANE_LOW;
            overflow <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_hs) wr_state <= WR_RESP;  // response next cycle
                WR_RESP: if (bready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
            if (wr_hs) begin
                bresp <= OKAY;
                case (wr_addr)
                    REG_CTRL: begin
                        if (wstrb[0]) begin               // both bits live in byte 0
                            src_sel  <= wdata[0];
                            ant_flag <= dac_lane_e'(wdata[1]);
                        end
                    end
                    REG_STATUS, REG_ID: ;                 // clear handled below, id is ro
                    default: bresp <= SLVERR;
                endcase
            end
            if (wr_full_hit)
                overflow <= 1'b1;                         // new drop beats the clear
            else if (ovf_clear)
                overflow <= 1'b0;
        end
    end

    assign arready = (rd_state == RD_IDLE);               // one read in flight
    assign rd_hs   = arvalid && arready;
    assign rvalid  = (rd_state == RD_DATA);

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (rd_hs) rd_state <= RD_DATA;
                RD_DATA: if (rready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge acc_clk) begin
        if (rd_hs) begin
            rresp <= OKAY;
            case (rd_addr)
                REG_CTRL:   rdata <= {30'd0, ant_flag, src_sel};
                REG_STATUS: rdata <= {31'd0, overflow};
                REG_ID:     rdata <= DAC_INTF_ID;
                default: begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end
            endcase
        end
    end

    // the master keeps a write address offered until the slave takes it
    a_awvalid_hold: assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

endmodule

/* bb_sample_pacer.sv */
// sample pacer pulling one upstream sample per period and writing it plus a zero
`include "dac_params.svh"
`timescale 1ns/1ps

module bb_sample_pacer
    import iq_pkg::*;
(
    input  logic       acc_clk,
    input  logic       acc_rstn,
    input  logic       enable,
    input  iq_sample_t data_from_acc,
    output logic       read_bb_fifo,
    output iq_sample_t wr_data,
    output logic       wr_en
);

    localparam int CNT_W = $clog2(`CLK_PER_SAMPLE);
    localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(`CLK_PER_SAMPLE - 1);

    logic [CNT_W-1:0] phase;

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            phase        <= '0;
            read_bb_fifo <= 1'b0;
            wr_en        <= 1'b0;
        end else begin
            if (!enable || phase == CNT_TOP)
                phase <= '0;                               // rests at 0 in dma mode
            else
                phase <= phase + 1'b1;
            read_bb_fifo <= enable && (phase == '0);       // ask upstream for the next one
            wr_en        <= enable && (phase <= CNT_W'(1)); // sample then stuffed zero
        end
    end

    // phase 0 carries the sample, phase 1 the inserted zero
    always_ff @(posedge acc_clk) begin
        wr_data <= (phase == '0) ? data_from_acc : '0;
    end

    // at most one upstream request per sample period
    a_one_read_per_period: assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        read_bb_fifo |=> !read_bb_fifo)
        else $error("read_bb_fifo high in two cycles in a row");

endmodule

/* async_iq_fifo.sv */
// dual-clock fwft fifo with gray pointers carrying iq samples into dac_clk
`include "dac_params.svh"
`timescale 1ns/1ps

module async_iq_fifo
    import iq_pkg::*;
(
    input  logic       acc_clk,
    input  logic       acc_rstn,
    input  iq_sample_t wr_data,
    input  logic       wr_en,
    output logic       full,
    output logic       wr_full_hit,
    input  logic       dac_clk,
    output logic       dac_rstn,
    output iq_sample_t rd_data,
    input  logic       rd_en,
    output logic       empty
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    iq_sample_t                    mem [`FIFO_DEPTH];
    logic [AW:0]                   wr_bin, wr_gray, wr_bin_next, wr_gray_next;
    logic [AW:0]                   rd_bin, rd_gray, rd_bin_next, rd_gray_next;
    logic [`SYNC_STAGES-1:0][AW:0] rd_gray_sync; // read pointer into acc_clk
    logic [`SYNC_STAGES-1:0][AW:0] wr_gray_sync; // write pointer into dac_clk
    logic [AW:0]                   rd_gray_w, wr_gray_r;
    logic [`SYNC_STAGES-1:0]       rstn_sync;
    logic                          wr_inc, rd_inc;

    // write side, acc_clk
    assign wr_inc       = wr_en & ~full;                  // writes while full are dropped
    assign wr_bin_next  = wr_bin + {{AW{1'b0}}, wr_inc};
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
    assign rd_gray_w    = rd_gray_sync[`SYNC_STAGES-1];

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_sync <= '0;
            full         <= 1'b0;
            wr_full_hit  <= 1'b0;
        end else begin
            wr_bin       <= wr_bin_next;
            wr_gray      <= wr_gray_next;
            rd_gray_sync <= {rd_gray_sync[`SYNC_STAGES-2:0], rd_gray};
            full         <= (wr_gray_next == {~rd_gray_w[AW:AW-1], rd_gray_w[AW-2:0]});
            wr_full_hit  <= wr_en & full;                 // one-cycle overflow event
        end
    end

    always_ff @(posedge acc_clk) begin
        if (wr_inc)
            mem[wr_bin[AW-1:0]] <= wr_data;
    end

    // read reset follows acc_rstn through the dac_clk chain
    always_ff @(posedge dac_clk) begin
        rstn_sync <= {rstn_sync[`SYNC_STAGES-2:0], acc_rstn};
    end

    assign dac_rstn = rstn_sync[`SYNC_STAGES-1];

    // read side, dac_clk
    assign rd_inc       = rd_en & ~empty;
    assign rd_bin_next  = rd_bin + {{AW{1'b0}}, rd_inc};
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;
    assign wr_gray_r    = wr_gray_sync[`SYNC_STAGES-1];

    always_ff @(posedge dac_clk) begin
        if (!dac_rstn) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_sync <= '0;
            empty        <= 1'b1;
        end else begin
            rd_bin       <= rd_bin_next;
            rd_gray      <= rd_gray_next;
            wr_gray_sync <= {wr_gray_sync[`SYNC_STAGES-2:0], wr_gray};
            empty        <= (rd_gray_next == wr_gray_r); // registered, adds the third cycle
        end
    end

    assign rd_data = empty ? '0 : mem[rd_bin[AW-1:0]];    // head word, zero on underflow

    // a low full flag never hides a write pointer a whole depth ahead
    a_full_flag_safe: assert property (@(posedge acc_clk) disable iff (!acc_rstn)
        !full |-> wr_gray != {~rd_gray_w[AW:AW-1], rd_gray_w[AW-2:0]})
        else $error("full low while the write pointer is a whole depth ahead");

    // a low empty flag never hides a read pointer that caught up
    a_empty_flag_safe: assert property (@(posedge dac_clk) disable iff (!dac_rstn)
        !empty |-> rd_gray != wr_gray_r)
        else $error("empty low while the read pointer has caught up");

endmodule

/* dac_output_mux.sv */
// dac side control synchronizers, lane placement and dma/accelerator source mux
`include "dac_params.svh"
`timescale 1ns/1ps

module dac_output_mux
    import iq_pkg::*;
(
    input  logic                       dac_clk,
    input  logic                       dac_rstn,
    input  logic                       src_sel,
    input  dac_lane_e                  ant_flag,
    input  iq_sample_t                 rd_data,
    input  logic                       empty,
    output logic                       rd_en,
    input  logic [`DAC_PACK_WIDTH-1:0] dma_data,
    input  logic                       dma_valid,
    output logic                       dma_ready,
    output logic [`DAC_PACK_WIDTH-1:0] dac_data,
    output logic                       dac_valid,
    input  logic                       dac_ready
);

    logic [`SYNC_STAGES_CTRL-1:0] src_sync;
    logic [`SYNC_STAGES_CTRL-1:0] ant_sync;
    logic                         src_acc;
    dac_lane_e                    lane;
    logic [`DAC_PACK_WIDTH-1:0]   placed;

    // quasi-static bits from the register block
    always_ff @(posedge dac_clk) begin
        if (!dac_rstn) begin
            src_sync <= '0;                                // dma owns the dac out of reset
            ant_sync <= '0;
        end else begin
            src_sync <= {src_sync[`SYNC_STAGES_CTRL-2:0], src_sel};
            ant_sync <= {ant_sync[`SYNC_STAGES_CTRL-2:0], ant_flag};
        end
    end

    assign src_acc = src_sync[`SYNC_STAGES_CTRL-1];
    assign lane    = dac_lane_e'(ant_sync[`SYNC_STAGES_CTRL-1]);

    // sample goes to one antenna, the other lane idles at zero
    assign placed = (lane == LANE_HIGH) ? {rd_data, {`IQ_PAIR_WIDTH{1'b0}}}
                                        : {{`IQ_PAIR_WIDTH{1'b0}}, rd_data};

    assign dac_data  = src_acc ? (empty ? '0 : placed) : dma_data; // underflow sends zeros
    assign dac_valid = src_acc ? 1'b1 : dma_valid;  // fixed dac rate in accelerator mode
    assign dma_ready = src_acc ? 1'b0 : dac_ready;
    assign rd_en     = src_acc & dac_ready;

endmodule

/* dac_intf_top.sv */
// tx baseband to dac bridge: registers, pacer, clock crossing fifo and output mux
`include "dac_params.svh"
`timescale 1ns/1ps

module dac_intf_top
    import iq_pkg::*, regs_pkg::*;
(
    input  logic                       acc_clk,
    input  logic                       acc_rstn,
    input  logic                       dac_clk,
    input  logic [REG_ADDR_W-1:0]      awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [REG_ADDR_W-1:0]      araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic [`IQ_PAIR_WIDTH-1:0]  data_from_acc,
    output logic                       read_bb_fifo,
    input  logic [`DAC_PACK_WIDTH-1:0] dma_data,
    input  logic                       dma_valid,
    output logic                       dma_ready,
    output logic [`DAC_PACK_WIDTH-1:0] dac_data,
    output logic                       dac_valid,
    input  logic                       dac_ready
);

    logic       src_sel;
    dac_lane_e  ant_flag;
    logic       wr_full_hit;
    iq_sample_t wr_data;
    logic       wr_en;
    iq_sample_t rd_data;
    logic       rd_en;
    logic       empty;
    logic       dac_rstn;  // acc_rstn retimed into dac_clk by the fifo

    dac_ctrl_regs regs0 (
        .acc_clk, .acc_rstn,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .wr_full_hit, .src_sel, .ant_flag
    );

    bb_sample_pacer pacer0 (
        .acc_clk, .acc_rstn,
        .enable        (src_sel),       // pacing only while the accelerator feeds the dac
        .data_from_acc (data_from_acc),
        .read_bb_fifo, .wr_data, .wr_en
    );

    async_iq_fifo fifo0 (
        .acc_clk, .acc_rstn, .wr_data, .wr_en,
        .full          (),              // drops are reported through wr_full_hit
        .wr_full_hit, .dac_clk, .dac_rstn, .rd_data, .rd_en, .empty
    );

    dac_output_mux mux0 (
        .dac_clk, .dac_rstn, .src_sel, .ant_flag, .rd_data, .empty, .rd_en,
        .dma_data, .dma_valid, .dma_ready, .dac_data, .dac_valid, .dac_ready
    );

endmodule

/* dac_intf_tb.sv */
// directed testbench for the tx baseband to dac bridge with upstream, dma and dac models
`include "dac_params.svh"
`timescale 1ns/1ps

module dac_intf_tb;
    localparam int DMA_N = 60, RUN_N = 120, OVF_N = 80;  // dma beats, acc cycles per stream run
    localparam int LIMIT = 6 * (DMA_N + 2 * RUN_N + OVF_N) + 600; // acc_clk cycles before timeout

    logic acc_clk = 0, dac_clk = 0, acc_rstn;
    logic [3:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready, awready, wready, bvalid, arready, rvalid;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [`IQ_PAIR_WIDTH-1:0] data_from_acc;
    logic read_bb_fifo, dma_valid, dma_ready, dac_valid, dac_ready;
    logic [`DAC_PACK_WIDTH-1:0] dma_data, dac_data;
    logic [31:0] exp_q[$];                               // samples handed out upstream
    logic [`DAC_PACK_WIDTH-1:0] rx_q[$];                 // words taken by the dac sink
    int seed = 32'h509e_a7b5;
    int n_mis = 0, n_oth = 0, cycles = 0;

    always #5 acc_clk = ~acc_clk;
    always #3.5 dac_clk = ~dac_clk;

    dac_intf_top dut0 (.*);

    function automatic logic [31:0] next_sample();
        logic [31:0] s;
        s = $random(seed);
        if (s == 0) s = 32'h0001_0001;                   // zero is reserved for stuffing
        return s;
    endfunction

    // upstream model, next sample is on the bus before the following capture
    always @(negedge acc_clk) begin
        if (read_bb_fifo) begin
            exp_q.push_back(data_from_acc);
            data_from_acc <= next_sample();
        end
    end

    always @(posedge dac_clk) begin
        if (dac_valid && dac_ready) rx_q.push_back(dac_data); // dac sink
    end

    always @(posedge acc_clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run exceeded %0d acc_clk cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic axi_write(input logic [3:0] a, input logic [31:0] d, output logic [1:0] r);
        @(negedge acc_clk);
        awaddr = a; wdata = d; wstrb = 4'hf; awvalid = 1; wvalid = 1;
        do @(posedge acc_clk); while (!(awready && wready));
        @(negedge acc_clk);
        awvalid = 0; wvalid = 0; bready = 1;
        while (!bvalid) @(negedge acc_clk);              // wait for the response
        r = bresp;
        @(negedge acc_clk);
        bready = 0;
    endtask

    task automatic axi_read(input logic [3:0] a, output logic [31:0] d, output logic [1:0] r);
        @(negedge acc_clk);
        araddr = a; arvalid = 1;
        do @(posedge acc_clk); while (!arready);
        @(negedge acc_clk);
        arvalid = 0; rready = 1;
        while (!rvalid) @(negedge acc_clk);
        d = rdata; r = rresp;
        @(negedge acc_clk);
        rready = 0;
    endtask

    task automatic expect_reg(input logic [3:0] a, input logic [31:0] v, input logic [1:0] rs);
        logic [31:0] d;
        logic [1:0] r;
        axi_read(a, d, r);
        assert (d == v && r == rs) else begin
            $display("MISMATCH rdata/rresp @%h: got %h/%h exp %h/%h", a, d, r, v, rs);
            n_mis++;
        end
    endtask

    task automatic set_ctrl(input logic [31:0] v);       // stalls the dac while bits resync
        logic [1:0] r;
        @(negedge dac_clk) dac_ready = 0;
        axi_write(4'h0, v, r);
        repeat (10) @(negedge dac_clk);
    endtask

    task automatic register_access();
        logic [1:0] r;
        axi_write(4'h0, 32'h2, r);
        expect_reg(4'h0, 32'h2, 2'b00);                  // ant high, dma source
        axi_write(4'h0, 32'h0, r);
        expect_reg(4'h0, 32'h0, 2'b00);
        expect_reg(4'h8, 32'hdac0_0102, 2'b00);
        expect_reg(4'hc, 32'h0, 2'b10);                  // unmapped read
        axi_write(4'hc, 32'h5, r);
        assert (r == 2'b10) else begin
            $display("MISMATCH bresp: got %h exp %h", r, 2'b10);
            n_mis++;
        end
    endtask

    task automatic dma_bypass();
        logic [`DAC_PACK_WIDTH-1:0] sent_q[$];           // beats the dac should take
        logic [31:0] rnd;
        repeat (DMA_N) begin
            @(negedge dac_clk);
            dma_data = {$random(seed), $random(seed)};
            rnd = $random(seed);
            dma_valid = rnd[0];
            dac_ready = rnd[1];
            if (dma_valid && dac_ready) sent_q.push_back(dma_data);
            #1;
            assert (dma_ready == dac_ready && dac_valid == dma_valid) else begin
                $display("MISMATCH dma_ready/dac_valid: got %h/%h exp %h/%h",
                         dma_ready, dac_valid, dac_ready, dma_valid);
                n_mis++;
            end
        end
        @(negedge dac_clk) dma_valid = 0;
        assert (rx_q.size() == sent_q.size()) else begin
            $display("dac sink took %0d dma beats but %0d were offered",
                     rx_q.size(), sent_q.size());
            n_oth++;
        end
        foreach (sent_q[k]) begin
            if (k < rx_q.size())
                assert (rx_q[k] == sent_q[k]) else begin
                    $display("MISMATCH dac_data: got %h exp %h", rx_q[k], sent_q[k]);
                    n_mis++;
                end
        end
        rx_q.delete();
    endtask

    // strict: every sample arrives in order with a zero after it, else an ordered subset
    task automatic check_stream(input bit high, input bit strict);
        logic [31:0] s, o;
        bit prev_nz;
        int got;
        prev_nz = 0;
        got = 0;
        foreach (rx_q[k]) begin
            s = high ? rx_q[k][63:32] : rx_q[k][31:0];
            o = high ? rx_q[k][31:0] : rx_q[k][63:32];
            assert (o == 0) else begin
                $display("MISMATCH dac_data idle lane: got %h exp %h", o, 32'h0);
                n_mis++;
            end
            if (s != 0) begin
                got++;
                if (strict && prev_nz) begin
                    $display("two samples arrived with no stuffed zero between them");
                    n_oth++;
                end
                while (!strict && exp_q.size() > 0 && exp_q[0] != s) void'(exp_q.pop_front());
                if (exp_q.size() == 0) begin
                    $display("sample %h arrived that was never sent", s);
                    n_oth++;
                end else begin
                    assert (exp_q[0] == s) else begin
                        $display("MISMATCH dac_data sample: got %h exp %h", s, exp_q[0]);
                        n_mis++;
                    end
                    void'(exp_q.pop_front());
                end
            end
            prev_nz = (s != 0);
        end
        if (got == 0) begin
            $display("no samples reached the dac");
            n_oth++;
        end
        rx_q.delete();
    endtask

    task automatic run_stream(input int n, input bit high, input bit strict);
        @(negedge dac_clk) dac_ready = 1;
        repeat (n) @(negedge acc_clk);
        @(negedge dac_clk) dac_ready = 0;
        check_stream(high, strict);
    endtask

    task automatic overflow_recovery();
        logic [1:0] r;
        repeat (OVF_N) @(negedge acc_clk);               // fifo fills and drops
        expect_reg(4'h4, 32'h1, 2'b00);
        set_ctrl(32'h0);                                 // stop the pacer
        axi_write(4'h4, 32'h1, r);
        expect_reg(4'h4, 32'h0, 2'b00);
        set_ctrl(32'h1);
        run_stream(RUN_N, 1'b0, 1'b0);
    endtask

    initial begin
        acc_rstn = 0;
        awaddr = 0; araddr = 0; wdata = 0; wstrb = 0;
        awvalid = 0; wvalid = 0; bready = 0; arvalid = 0; rready = 0;
        data_from_acc = next_sample();
        dma_data = 0; dma_valid = 0; dac_ready = 0;
        repeat (5) @(negedge acc_clk);
        acc_rstn = 1;
        repeat (4) @(negedge acc_clk);
        register_access();
        dma_bypass();
        set_ctrl(32'h1);                                 // accelerator, low lane
        run_stream(RUN_N, 1'b0, 1'b1);
        set_ctrl(32'h3);                                 // accelerator, high lane
        run_stream(RUN_N, 1'b1, 1'b1);
        set_ctrl(32'h1);
        overflow_recovery();
        $display("errors: %0d mismatches, %0d other failures", n_mis, n_oth);
        if (n_mis + n_oth == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end
endmodule

/* files.f */
+incdir+.
iq_pkg.sv
regs_pkg.sv
dac_ctrl_regs.sv
bb_sample_pacer.sv
async_iq_fifo.sv
dac_output_mux.sv
dac_intf_top.sv
dac_intf_tb.sv

/* Bender.yml */
package:
  name: dac_intf

export_include_dirs:
  - .

sources:
  - iq_pkg.sv
  - regs_pkg.sv
  - dac_ctrl_regs.sv
  - bb_sample_pacer.sv
  - async_iq_fifo.sv
  - dac_output_mux.sv
  - dac_intf_top.sv
  - target: test
    files:
      - dac_intf_tb.sv
